// ==== hdl/bridge_pkg.sv ====
package bridge_pkg;

    localparam int LINE_WORDS = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [LINE_WORDS*$bits(word_t)-1:0] line_t;

    localparam int WORD_BYTES       = $bits(word_t) / 8;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_WORDS * WORD_BYTES);

    typedef logic [$bits(addr_t)-LINE_OFFSET_BITS-1:0] line_addr_t;

    // request type codes as the caches drive them
    typedef logic [2:0] req_type_t;
    localparam req_type_t TYPE_BYTE = 3'd0;
    localparam req_type_t TYPE_HALF = 3'd1;
    localparam req_type_t TYPE_WORD = 3'd2;
    localparam req_type_t TYPE_LINE = 3'd4;

    typedef logic [3:0] axi_id_t;
    localparam axi_id_t ID_INST = 4'd0;
    localparam axi_id_t ID_DATA = 4'd1;

    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] beat_cnt_t;

    typedef struct packed {
        addr_t     addr;
        req_type_t req_type;
    } rd_req_t;

    // word writes carry their data in the low word of the line
    typedef struct packed {
        addr_t     addr;
        req_type_t req_type;
        strb_t     strb;
        line_t     data;
    } wr_req_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } ret_beat_t;

    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        axi_len_t  len;
        axi_size_t size;
    } axi_ar_t;

    typedef struct packed {
        addr_t     addr;
        axi_len_t  len;
        axi_size_t size;
    } axi_aw_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        word_t   data;
        logic    last;
    } axi_r_t;

    typedef struct packed {
        logic       busy;
        line_addr_t line_addr;
    } wr_pend_t;

    function automatic axi_len_t type_len(req_type_t t);
        return (t == TYPE_LINE) ? axi_len_t'(LINE_WORDS - 1) : axi_len_t'(0);
    endfunction

    // non-line types already encode log2 of their byte count
    function automatic axi_size_t type_size(req_type_t t);
        return (t == TYPE_LINE) ? axi_size_t'($clog2(WORD_BYTES)) : axi_size_t'(t);
    endfunction

    function automatic line_addr_t line_addr_of(addr_t a);
        return a[$bits(addr_t)-1:LINE_OFFSET_BITS];
    endfunction

endpackage

// ==== hdl/burst_beat_counter.sv ====
`timescale 1ns/1ps

module burst_beat_counter
    import bridge_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      load,
    input  beat_cnt_t load_len,
    input  logic      beat_taken,
    output logic      last_beat
);

    // beats left after the current one
    beat_cnt_t count;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_len;
        end else if (beat_taken && !last_beat) begin
            count <= count - 1'b1;
        end
    end

    assign last_beat = (count == '0);

    // no beat follows the final one of a burst
    no_wrap_a: assert property (
        @(posedge aclk) disable iff (!rst_n)
        beat_taken && last_beat |=> !beat_taken
    );

endmodule

// ==== hdl/write_data_serializer.sv ====
`timescale 1ns/1ps

module write_data_serializer
    import bridge_pkg::*;
(
    input  logic    aclk,
    input  logic    load,
    input  wr_req_t dcache_wr,
    input  logic    beat_taken,
    input  logic    last_beat,
    output axi_w_t  w
);

    line_t line_q;
    strb_t strb_q;

    always_ff @(posedge aclk) begin
        if (load) begin
            line_q <= dcache_wr.data;
            // full line goes out with every byte enabled
            if (dcache_wr.req_type == TYPE_LINE) begin
                strb_q <= strb_t'('1);
            end else begin
                strb_q <= dcache_wr.strb;
            end
        end else if (beat_taken) begin
            line_q <= line_q >> $bits(word_t);
        end
    end

    assign w = '{
        data: line_q[$bits(word_t)-1:0],
        strb: strb_q,
        last: last_beat
    };

endmodule

// ==== hdl/write_ctrl_fsm.sv ====
`timescale 1ns/1ps

module write_ctrl_fsm
    import bridge_pkg::*;
(
    input  logic     aclk,
    input  logic     rst_n,
    input  logic     dcache_wr_req,
    input  wr_req_t  dcache_wr,
    output logic     dcache_wr_rdy,
    output logic     dcache_wr_bvalid,
    output axi_aw_t  aw,
    output logic     awvalid,
    input  logic     awready,
    output logic     wvalid,
    input  logic     wready,
    input  logic     last_beat,
    input  logic     bvalid,
    output logic     load,
    output wr_pend_t wr_pend
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } wr_state_e;

    wr_state_e state;
    wr_state_e state_next;
    axi_aw_t   aw_q;
    axi_aw_t   aw_req;
    logic      accept;

    assign dcache_wr_rdy = (state == ST_IDLE);
    assign accept        = dcache_wr_req && dcache_wr_rdy;
    assign load          = accept;

    assign aw_req = '{
        addr: dcache_wr.addr,
        len:  type_len(dcache_wr.req_type),
        size: type_size(dcache_wr.req_type)
    };

    // request fields show through while idle so the counter sees the length on load
    assign aw = (state == ST_IDLE) ? aw_req : aw_q;

    assign awvalid          = (state == ST_ADDR);
    assign wvalid           = (state == ST_DATA);
    assign dcache_wr_bvalid = (state == ST_RESP) && bvalid;

    assign wr_pend = '{busy: (state != ST_IDLE) || accept, line_addr: line_addr_of(aw.addr)};

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_next = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (awready) begin
                    state_next = ST_DATA;
                end
            end
            ST_DATA: begin
                if (wready && last_beat) begin
                    state_next = ST_RESP;
                end
            end
            default: begin
                if (bvalid) begin
                    state_next = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            aw_q <= aw_req;
        end
    end

    // beat counter already holds this burst's length
    burst_loaded_a: assert property (
        @(posedge aclk) disable iff (!rst_n)
        awvalid |-> last_beat == (aw.len == '0)
    );

endmodule

// ==== hdl/read_channel.sv ====
`timescale 1ns/1ps

module read_channel
    import bridge_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    // instruction cache
    input  logic      icache_rd_req,
    input  rd_req_t   icache_rd,
    output logic      icache_rd_rdy,
    output logic      icache_ret_valid,
    output ret_beat_t icache_ret,
    // data cache
    input  logic      dcache_rd_req,
    input  rd_req_t   dcache_rd,
    output logic      dcache_rd_rdy,
    output logic      dcache_ret_valid,
    output ret_beat_t dcache_ret,
    // axi read
    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    // write in progress
    input  wr_pend_t  wr_pend
);

    logic    busy_inst;
    logic    busy_data;
    logic    raw_hazard;
    logic    inst_accept;
    logic    data_accept;
    logic    inst_done;
    logic    data_done;
    rd_req_t winner;
    axi_id_t winner_id;

    // data read to a line that is still being written back
    assign raw_hazard = wr_pend.busy &&
                        (wr_pend.line_addr == line_addr_of(dcache_rd.addr));

    assign dcache_rd_rdy = !arvalid && !busy_data && !raw_hazard;
    // dcache has priority
    assign icache_rd_rdy = !arvalid && !busy_inst && !(dcache_rd_req && dcache_rd_rdy);

    assign data_accept = dcache_rd_req && dcache_rd_rdy;
    assign inst_accept = icache_rd_req && icache_rd_rdy;

    assign winner    = data_accept ? dcache_rd : icache_rd;
    assign winner_id = data_accept ? ID_DATA : ID_INST;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (inst_accept || data_accept) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_accept || data_accept) begin
            ar.id   <= winner_id;
            ar.addr <= winner.addr;
            ar.len  <= type_len(winner.req_type);
            ar.size <= type_size(winner.req_type);
        end
    end

    assign inst_done = rvalid && r.last && (r.id == ID_INST);
    assign data_done = rvalid && r.last && (r.id == ID_DATA);

    // one read in flight per id
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            busy_inst <= 1'b0;
            busy_data <= 1'b0;
        end else begin
            if (inst_accept) begin
                busy_inst <= 1'b1;
            end else if (inst_done) begin
                busy_inst <= 1'b0;
            end
            if (data_accept) begin
                busy_data <= 1'b1;
            end else if (data_done) begin
                busy_data <= 1'b0;
            end
        end
    end

    // r beats steered by rid
    assign icache_ret_valid = rvalid && (r.id == ID_INST);
    assign dcache_ret_valid = rvalid && (r.id == ID_DATA);
    assign icache_ret       = '{data: r.data, last: r.last};
    assign dcache_ret       = '{data: r.data, last: r.last};

    ar_stable_a: assert property (
        @(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar)
    );

    // r beats only for an id with a read in flight
    r_id_busy_a: assert property (
        @(posedge aclk) disable iff (!rst_n)
        rvalid |-> (r.id == ID_INST && busy_inst) || (r.id == ID_DATA && busy_data)
    );

endmodule

// ==== hdl/cache_axi_bridge.sv ====
`timescale 1ns/1ps

module cache_axi_bridge
    import bridge_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    // instruction cache reads
    input  logic      icache_rd_req,
    input  rd_req_t   icache_rd,
    output logic      icache_rd_rdy,
    output logic      icache_ret_valid,
    output ret_beat_t icache_ret,
    // data cache reads
    input  logic      dcache_rd_req,
    input  rd_req_t   dcache_rd,
    output logic      dcache_rd_rdy,
    output logic      dcache_ret_valid,
    output ret_beat_t dcache_ret,
    // data cache writes
    input  logic      dcache_wr_req,
    input  wr_req_t   dcache_wr,
    output logic      dcache_wr_rdy,
    output logic      dcache_wr_bvalid,
    // axi
    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  logic      bvalid
);

    wr_pend_t  wr_pend;
    logic      load;
    logic      last_beat;
    logic      beat_taken;
    beat_cnt_t load_len;

    assign beat_taken = wvalid && wready;
    assign load_len   = beat_cnt_t'(aw.len);

    read_channel read_channel_i (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .icache_rd_req    (icache_rd_req),
        .icache_rd        (icache_rd),
        .icache_rd_rdy    (icache_rd_rdy),
        .icache_ret_valid (icache_ret_valid),
        .icache_ret       (icache_ret),
        .dcache_rd_req    (dcache_rd_req),
        .dcache_rd        (dcache_rd),
        .dcache_rd_rdy    (dcache_rd_rdy),
        .dcache_ret_valid (dcache_ret_valid),
        .dcache_ret       (dcache_ret),
        .ar               (ar),
        .arvalid          (arvalid),
        .arready          (arready),
        .r                (r),
        .rvalid           (rvalid),
        .wr_pend          (wr_pend)
    );

    write_ctrl_fsm write_ctrl_fsm_i (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .dcache_wr_req    (dcache_wr_req),
        .dcache_wr        (dcache_wr),
        .dcache_wr_rdy    (dcache_wr_rdy),
        .dcache_wr_bvalid (dcache_wr_bvalid),
        .aw               (aw),
        .awvalid          (awvalid),
        .awready          (awready),
        .wvalid           (wvalid),
        .wready           (wready),
        .last_beat        (last_beat),
        .bvalid           (bvalid),
        .load             (load),
        .wr_pend          (wr_pend)
    );

    write_data_serializer write_data_serializer_i (
        .aclk       (aclk),
        .load       (load),
        .dcache_wr  (dcache_wr),
        .beat_taken (beat_taken),
        .last_beat  (last_beat),
        .w          (w)
    );

    burst_beat_counter burst_beat_counter_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .load       (load),
        .load_len   (load_len),
        .beat_taken (beat_taken),
        .last_beat  (last_beat)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic rst_n
);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;
    end

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model
    import bridge_pkg::*;
(
    input  logic    aclk,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output logic    bvalid
);

    // written words, keyed by word address
    word_t   overlay [addr_t];
    axi_ar_t rd_q [$];
    axi_aw_t wr_q [$];
    int      r_beat;
    int      w_beat;
    int      b_pending;

    function automatic word_t read_word(addr_t widx);
        if (overlay.exists(widx)) begin
            return overlay[widx];
        end
        return widx ^ 32'ha5a50000;
    endfunction

    function automatic void store_word(addr_t widx, word_t data, strb_t strb);
        word_t cur;
        cur = read_word(widx);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                cur[8*b +: 8] = data[8*b +: 8];
            end
        end
        overlay[widx] = cur;
    endfunction

    // single process so the random sequence comes from one seed
    initial begin
        addr_t widx;
        void'($urandom(32'h6e7ac63e));
        arready   = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        rvalid    = 1'b0;
        r         = '0;
        r_beat    = 0;
        w_beat    = 0;
        b_pending = 0;
        forever begin
            @(posedge aclk);
            if (arvalid && arready) begin
                rd_q.push_back(ar);
            end
            // r and b beats are always taken by the bridge
            if (rvalid) begin
                if (r.last) begin
                    void'(rd_q.pop_front());
                    r_beat = 0;
                end else begin
                    r_beat++;
                end
            end
            if (awvalid && awready) begin
                wr_q.push_back(aw);
            end
            if (wvalid && wready) begin
                widx = (wr_q[0].addr >> 2) + w_beat;
                store_word(widx, w.data, w.strb);
                if (w.last) begin
                    void'(wr_q.pop_front());
                    w_beat = 0;
                    b_pending++;
                end else begin
                    w_beat++;
                end
            end
            if (bvalid) begin
                b_pending--;
            end
            arready <= ($urandom % 4) != 0;
            awready <= ($urandom % 4) != 0;
            wready  <= (wr_q.size() > 0) && (($urandom % 4) != 0);
            bvalid  <= (b_pending > 0) && (($urandom % 4) != 0);
            if (rd_q.size() > 0 && ($urandom % 4) != 0) begin
                widx = (rd_q[0].addr >> 2) + r_beat;
                rvalid <= 1'b1;
                r      <= '{id: rd_q[0].id, data: read_word(widx), last: r_beat == rd_q[0].len};
            end else begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== verif/cache_axi_bridge_tb.sv ====
`timescale 1ns/1ps

module cache_axi_bridge_tb
    import bridge_pkg::*;
();

    localparam int NUM_ROWS       = 14;
    localparam int TIMEOUT_CYCLES = 300 * NUM_ROWS;
    localparam logic [1:0] OP_IREAD  = 2'd0;
    localparam logic [1:0] OP_DREAD  = 2'd1;
    localparam logic [1:0] OP_DWRITE = 2'd2;

    // together means issue in the same cycle as the next row
    typedef struct packed {
        logic [1:0] op;
        addr_t      addr;
        req_type_t  rtype;
        strb_t      strb;
        line_t      data;
        logic       together;
    } row_t;

    logic      aclk;
    logic      rst_n;
    logic      icache_rd_req;
    rd_req_t   icache_rd;
    logic      icache_rd_rdy;
    logic      icache_ret_valid;
    ret_beat_t icache_ret;
    logic      dcache_rd_req;
    rd_req_t   dcache_rd;
    logic      dcache_rd_rdy;
    logic      dcache_ret_valid;
    ret_beat_t dcache_ret;
    logic      dcache_wr_req;
    wr_req_t   dcache_wr;
    logic      dcache_wr_rdy;
    logic      dcache_wr_bvalid;
    axi_ar_t   ar;
    logic      arvalid;
    logic      arready;
    axi_r_t    r;
    logic      rvalid;
    axi_aw_t   aw;
    logic      awvalid;
    logic      awready;
    axi_w_t    w;
    logic      wvalid;
    logic      wready;
    logic      bvalid;

    row_t       table_rows [NUM_ROWS];
    word_t      shadow [addr_t];
    axi_ar_t    ar_log [$];
    axi_aw_t    aw_seen;
    axi_w_t     w_seen [$];
    int         bresp_count = 0;
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    logic       wr_open     = 1'b0;
    line_addr_t wr_line;
    logic       prev_arwait = 1'b0;
    logic       prev_awwait = 1'b0;
    logic       prev_wwait  = 1'b0;
    axi_ar_t    prev_ar;
    axi_aw_t    prev_aw;
    axi_w_t     prev_w;

    tb_clock_gen tb_clock_gen_i (.aclk(aclk), .rst_n(rst_n));
    cache_axi_bridge cache_axi_bridge_i (.*);
    axi_mem_model axi_mem_model_i (.*);

    function automatic word_t expected_word(addr_t widx);
        if (shadow.exists(widx)) begin
            return shadow[widx];
        end
        return widx ^ 32'ha5a50000;
    endfunction

    function automatic axi_len_t burst_len_for(req_type_t t);
        return (t == TYPE_LINE) ? 8'd3 : 8'd0;
    endfunction

    function automatic axi_size_t beat_size_for(req_type_t t);
        return (t == TYPE_LINE) ? 3'd2 : t;
    endfunction

    function automatic void check_value(string name, logic [31:0] got, logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endfunction

    function automatic void note_failure(string what);
        error_count++;
        $display("%s", what);
    endfunction

    function automatic void set_row(int idx, logic [1:0] op, addr_t addr, req_type_t rtype,
                                    strb_t strb, line_t data, logic together);
        table_rows[idx] = '{op: op, addr: addr, rtype: rtype, strb: strb, data: data,
                            together: together};
    endfunction

    function automatic void merge_write(row_t rw);
        int    beats;
        strb_t strb;
        word_t cur;
        addr_t widx;
        beats = (rw.rtype == TYPE_LINE) ? LINE_WORDS : 1;
        strb  = (rw.rtype == TYPE_LINE) ? 4'hf : rw.strb;
        for (int k = 0; k < beats; k++) begin
            widx = (rw.addr >> 2) + k;
            cur  = expected_word(widx);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    cur[8*b +: 8] = rw.data[32*k + 8*b +: 8];
                end
            end
            shadow[widx] = cur;
        end
    endfunction

    task automatic issue_read(row_t rw);
        logic      is_inst;
        int        beats;
        int        got;
        int        ar_idx;
        logic      valid_now;
        ret_beat_t beat_now;
        axi_ar_t   seen;
        string     ret_name;
        is_inst  = (rw.op == OP_IREAD);
        beats    = (rw.rtype == TYPE_LINE) ? LINE_WORDS : 1;
        ret_name = is_inst ? "icache_ret" : "dcache_ret";
        if (is_inst) begin
            icache_rd_req <= 1'b1;
            icache_rd     <= '{addr: rw.addr, req_type: rw.rtype};
        end else begin
            dcache_rd_req <= 1'b1;
            dcache_rd     <= '{addr: rw.addr, req_type: rw.rtype};
        end
        do begin
            @(posedge aclk);
        end while (!(is_inst ? icache_rd_rdy : dcache_rd_rdy));
        // the ar slot is empty here, so this read owns the next ar handshake
        ar_idx = ar_log.size();
        if (is_inst) begin
            icache_rd_req <= 1'b0;
        end else begin
            dcache_rd_req <= 1'b0;
        end
        got = 0;
        while (got < beats) begin
            @(posedge aclk);
            valid_now = is_inst ? icache_ret_valid : dcache_ret_valid;
            beat_now  = is_inst ? icache_ret : dcache_ret;
            if (valid_now) begin
                check_value({ret_name, ".data"}, beat_now.data,
                            expected_word((rw.addr >> 2) + got));
                check_value({ret_name, ".last"}, beat_now.last, got == beats - 1);
                got++;
            end
        end
        @(negedge aclk);
        if (ar_idx < ar_log.size()) begin
            seen = ar_log[ar_idx];
            check_value("ar.id", seen.id, is_inst ? ID_INST : ID_DATA);
            check_value("ar.addr", seen.addr, rw.addr);
            check_value("ar.len", seen.len, burst_len_for(rw.rtype));
            check_value("ar.size", seen.size, beat_size_for(rw.rtype));
        end else begin
            note_failure("no ar handshake was seen for this read");
        end
    endtask

    task automatic issue_write(row_t rw);
        int    beats;
        int    w_start;
        int    b_start;
        strb_t strb_exp;
        beats    = (rw.rtype == TYPE_LINE) ? LINE_WORDS : 1;
        strb_exp = (rw.rtype == TYPE_LINE) ? 4'hf : rw.strb;
        merge_write(rw);
        w_start = w_seen.size();
        b_start = bresp_count;
        dcache_wr_req <= 1'b1;
        dcache_wr     <= '{addr: rw.addr, req_type: rw.rtype, strb: rw.strb, data: rw.data};
        do begin
            @(posedge aclk);
        end while (!dcache_wr_rdy);
        dcache_wr_req <= 1'b0;
        do begin
            @(posedge aclk);
        end while (!dcache_wr_bvalid);
        @(posedge aclk);
        @(negedge aclk);
        check_value("dcache_wr_bvalid pulses", bresp_count - b_start, 1);
        check_value("aw.addr", aw_seen.addr, rw.addr);
        check_value("aw.len", aw_seen.len, burst_len_for(rw.rtype));
        check_value("aw.size", aw_seen.size, beat_size_for(rw.rtype));
        check_value("w beats", w_seen.size() - w_start, beats);
        for (int k = 0; k < beats && w_start + k < w_seen.size(); k++) begin
            check_value("w.data", w_seen[w_start + k].data, rw.data[32*k +: 32]);
            check_value("w.strb", w_seen[w_start + k].strb, strb_exp);
            check_value("w.last", w_seen[w_start + k].last, k == beats - 1);
        end
    endtask

    task automatic apply_row(int idx);
        row_t  rw;
        int    err_start;
        string name;
        rw        = table_rows[idx];
        err_start = error_count;
        if (rw.op == OP_DWRITE) begin
            issue_write(rw);
            name = "dcache write";
        end else begin
            issue_read(rw);
            name = (rw.op == OP_IREAD) ? "icache read" : "dcache read";
        end
        $display("row %0d %s addr %h: %s", idx, name, rw.addr,
                 (error_count == err_start) ? "ok" : "mismatch");
    endtask

    // handshake log and protocol watch
    always @(posedge aclk) begin
        cycle_count++;
        if (rst_n) begin
            if (arvalid && arready) begin
                ar_log.push_back(ar);
            end
            if (awvalid && awready) begin
                aw_seen = aw;
            end
            if (wvalid && wready) begin
                w_seen.push_back(w);
            end
            if (dcache_wr_bvalid) begin
                bresp_count++;
            end
            if (icache_ret_valid && dcache_ret_valid) begin
                note_failure("both cache return valids were high in the same cycle");
            end
            if (wr_open && arvalid && ar.id == ID_DATA && ar.addr[31:4] == wr_line) begin
                note_failure("data read went out to a line whose write was still pending");
            end
            if (prev_arwait && (!arvalid || ar !== prev_ar)) begin
                note_failure("ar channel changed while waiting for arready");
            end
            if (prev_awwait && (!awvalid || aw !== prev_aw)) begin
                note_failure("aw channel changed while waiting for awready");
            end
            if (prev_wwait && (!wvalid || w !== prev_w)) begin
                note_failure("w channel changed while waiting for wready");
            end
            if (dcache_wr_bvalid) begin
                wr_open = 1'b0;
            end
            if (dcache_wr_req && dcache_wr_rdy) begin
                wr_open = 1'b1;
                wr_line = dcache_wr.addr[31:4];
            end
        end
        prev_arwait = arvalid && !arready;
        prev_awwait = awvalid && !awready;
        prev_wwait  = wvalid && !wready;
        prev_ar     = ar;
        prev_aw     = aw;
        prev_w      = w;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the table did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        int row_idx;
        icache_rd_req = 1'b0;
        icache_rd     = '0;
        dcache_rd_req = 1'b0;
        dcache_rd     = '0;
        dcache_wr_req = 1'b0;
        dcache_wr     = '0;
        set_row(0, OP_IREAD, 32'h0000_1000, TYPE_LINE, 4'h0, '0, 1'b0);
        set_row(1, OP_DREAD, 32'h0000_2003, TYPE_BYTE, 4'h0, '0, 1'b0);
        set_row(2, OP_DREAD, 32'h0000_2006, TYPE_HALF, 4'h0, '0, 1'b0);
        set_row(3, OP_DREAD, 32'h0000_2008, TYPE_WORD, 4'h0, '0, 1'b0);
        set_row(4, OP_DWRITE, 32'h0000_3000, TYPE_LINE, 4'h0,
                128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0, 1'b0);
        set_row(5, OP_DREAD, 32'h0000_3000, TYPE_LINE, 4'h0, '0, 1'b0);
        // byte lanes 0 and 2 only
        set_row(6, OP_DWRITE, 32'h0000_3014, TYPE_WORD, 4'b0101, 128'hdeadbeef, 1'b0);
        set_row(7, OP_DREAD, 32'h0000_3010, TYPE_LINE, 4'h0, '0, 1'b0);
        // read issued while the write to its line is pending
        set_row(8, OP_DWRITE, 32'h0000_4000, TYPE_LINE, 4'h0,
                128'h13579bdf_2468ace0_fedcba98_76543210, 1'b1);
        set_row(9, OP_DREAD, 32'h0000_4000, TYPE_LINE, 4'h0, '0, 1'b0);
        set_row(10, OP_IREAD, 32'h0000_5000, TYPE_LINE, 4'h0, '0, 1'b1);
        set_row(11, OP_DREAD, 32'h0000_6000, TYPE_LINE, 4'h0, '0, 1'b0);
        set_row(12, OP_IREAD, 32'h0000_7004, TYPE_WORD, 4'h0, '0, 1'b1);
        set_row(13, OP_DREAD, 32'h0000_3014, TYPE_WORD, 4'h0, '0, 1'b0);
        wait (rst_n === 1'b1);
        row_idx = 0;
        while (row_idx < NUM_ROWS) begin
            @(posedge aclk);
            if (table_rows[row_idx].together && row_idx + 1 < NUM_ROWS) begin
                fork
                    apply_row(row_idx);
                    apply_row(row_idx + 1);
                join
                row_idx += 2;
            end else begin
                apply_row(row_idx);
                row_idx++;
            end
        end
        repeat (2) @(posedge aclk);
        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/bridge_pkg.sv
hdl/burst_beat_counter.sv
hdl/write_data_serializer.sv
hdl/write_ctrl_fsm.sv
hdl/read_channel.sv
hdl/cache_axi_bridge.sv
verif/tb_clock_gen.sv
verif/axi_mem_model.sv
verif/cache_axi_bridge_tb.sv
